// File: logic/nn_pkg.sv
package nn_pkg;

    // Q4.12 samples, weights, bias and output
    localparam int DATA_W    = 16;
    localparam int DATA_FRAC = 12;

    // Q8.24 accumulator
    localparam int ACC_W    = 32;
    localparam int ACC_FRAC = 24;

    localparam int N_INPUTS = 8;
    localparam int IDX_W    = 3;

    // left shift that moves a Q4.12 word onto the Q8.24 binary point
    localparam int BIAS_SHIFT = ACC_FRAC - DATA_FRAC;

    // accumulator bits between the sign and the kept output window
    localparam int OVF_W = ACC_W - 1 - DATA_W - DATA_FRAC;

    localparam logic signed [DATA_W-1:0] OUT_MAX = {1'b0, {(DATA_W-1){1'b1}}};

    typedef struct packed {
        logic                 sign;
        logic [OVF_W-1:0]     ovf;
        logic [DATA_W-1:0]    keep;
        logic [DATA_FRAC-1:0] frac;
    } q_acc_fields_t;

    // one Q8.24 word, seen as a number by the MAC and as fields by the ReLU
    typedef union packed {
        logic [ACC_W-1:0] word;
        q_acc_fields_t    f;
    } q_acc_u;

endpackage

// File: logic/weight_store.sv
`timescale 1ns/1ps

module weight_store
    import nn_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     w_write,
    input  logic [3:0]               w_addr,
    input  logic signed [DATA_W-1:0] w_data,
    input  logic [IDX_W-1:0]         w_idx,
    output logic signed [DATA_W-1:0] weight,
    output logic signed [DATA_W-1:0] bias
);

    logic signed [DATA_W-1:0] weights [N_INPUTS];
    logic signed [DATA_W-1:0] bias_r;

    // addresses 0..7 hold weights, 8 holds the bias, the rest are dropped
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < N_INPUTS; i++) begin
                weights[i] <= '0;
            end
            bias_r <= '0;
        end else if (w_write) begin
            if (w_addr < 4'(N_INPUTS)) begin
                weights[w_addr[IDX_W-1:0]] <= w_data;
            end else if (w_addr == 4'(N_INPUTS)) begin
                bias_r <= w_data;
            end
        end
    end

    // combinational read for the MAC's current sample
    assign weight = weights[w_idx];
    assign bias   = bias_r;

    // host should only target the nine defined registers
    a_addr_range: assert property (
        @(posedge clk) disable iff (reset)
        w_write |-> (w_addr <= 4'(N_INPUTS))
    ) else $error("weight write to undefined address %0d", w_addr);

endmodule

// File: logic/neuron_mac.sv
`timescale 1ns/1ps

module neuron_mac
    import nn_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     x_valid,
    input  logic signed [DATA_W-1:0] x_data,
    output logic [IDX_W-1:0]         w_idx,
    input  logic signed [DATA_W-1:0] weight,
    input  logic signed [DATA_W-1:0] bias,
    output q_acc_u                   acc,
    output logic                     acc_valid
);

    // sample counter, wraps after the last sample of a vector
    logic [IDX_W-1:0] cnt;

    // stage 1 registers
    logic signed [ACC_W-1:0] prod;
    logic                    prod_valid;
    logic                    prod_first;
    logic                    prod_last;

    // bias moved to Q8.24
    logic signed [ACC_W-1:0] bias_q;

    assign w_idx = cnt;

    assign bias_q = {{(ACC_W - DATA_W - BIAS_SHIFT){bias[DATA_W-1]}},
                     bias,
                     {BIAS_SHIFT{1'b0}}};

    always_ff @(posedge clk) begin
        if (reset) begin
            cnt <= '0;
        end else if (x_valid) begin
            cnt <= cnt + 1'b1;
        end
    end

    // stage 1 product of two Q4.12 words is already Q8.24
    always_ff @(posedge clk) begin
        if (reset) begin
            prod_valid <= 1'b0;
            prod_first <= 1'b0;
            prod_last  <= 1'b0;
        end else begin
            prod_valid <= x_valid;
            if (x_valid) begin
                prod_first <= (cnt == '0);
                prod_last  <= (cnt == IDX_W'(N_INPUTS - 1));
            end
        end
    end

    always_ff @(posedge clk) begin
        if (x_valid) begin
            prod <= x_data * weight;
        end
    end

    // stage 2 seeds with the bias on the first product and wraps mod 2^32
    always_ff @(posedge clk) begin
        if (prod_valid) begin
            if (prod_first) begin
                acc.word <= bias_q + prod;
            end else begin
                acc.word <= $signed(acc.word) + prod;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            acc_valid <= 1'b0;
        end else begin
            acc_valid <= prod_valid & prod_last;
        end
    end

    // finished sums are at least one vector apart
    a_single_pulse: assert property (
        @(posedge clk) disable iff (reset)
        acc_valid |=> !acc_valid
    ) else $error("acc_valid high in two consecutive cycles");

endmodule

// File: logic/relu_sat.sv
`timescale 1ns/1ps

module relu_sat
    import nn_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset,
    input  q_acc_u                   acc,
    input  logic                     acc_valid,
    output logic signed [DATA_W-1:0] y_data,
    output logic                     y_valid
);

    logic too_big;

    // anything set above the output's sign position cannot fit in Q4.12
    assign too_big = (|acc.f.ovf) | acc.f.keep[DATA_W-1];

    always_ff @(posedge clk) begin
        if (reset) begin
            y_valid <= 1'b0;
        end else begin
            y_valid <= acc_valid;
        end
    end

    // y_data holds between results
    always_ff @(posedge clk) begin
        if (reset) begin
            y_data <= '0;
        end else if (acc_valid) begin
            if (acc.f.sign) begin
                // negative sums clip to zero
                y_data <= '0;
            end else if (too_big) begin
                y_data <= OUT_MAX;
            end else begin
                // low fraction bits are simply dropped
                y_data <= acc.f.keep;
            end
        end
    end

    // the ReLU never lets a negative value out
    a_non_negative: assert property (
        @(posedge clk) disable iff (reset)
        y_valid |-> !y_data[DATA_W-1]
    ) else $error("negative output 0x%h from relu", y_data);

endmodule

// File: logic/dense_neuron.sv
`timescale 1ns/1ps

module dense_neuron
    import nn_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     w_write,
    input  logic [3:0]               w_addr,
    input  logic signed [DATA_W-1:0] w_data,
    input  logic                     x_valid,
    input  logic signed [DATA_W-1:0] x_data,
    output logic                     y_valid,
    output logic signed [DATA_W-1:0] y_data
);

    logic [IDX_W-1:0]         w_idx;
    logic signed [DATA_W-1:0] weight;
    logic signed [DATA_W-1:0] bias;
    q_acc_u                   acc;
    logic                     acc_valid;

    weight_store u_weight_store (
        .clk     (clk),
        .reset   (reset),
        .w_write (w_write),
        .w_addr  (w_addr),
        .w_data  (w_data),
        .w_idx   (w_idx),
        .weight  (weight),
        .bias    (bias)
    );

    neuron_mac u_neuron_mac (
        .clk       (clk),
        .reset     (reset),
        .x_valid   (x_valid),
        .x_data    (x_data),
        .w_idx     (w_idx),
        .weight    (weight),
        .bias      (bias),
        .acc       (acc),
        .acc_valid (acc_valid)
    );

    relu_sat u_relu_sat (
        .clk       (clk),
        .reset     (reset),
        .acc       (acc),
        .acc_valid (acc_valid),
        .y_data    (y_data),
        .y_valid   (y_valid)
    );

endmodule

// File: test/neuron_checker.sv
`timescale 1ns/1ps

module neuron_checker
    import nn_pkg::*;
#(
    parameter int DRAIN_LIMIT = 20
) (
    input logic                     clk,
    input logic                     reset,
    input logic                     y_valid,
    input logic signed [DATA_W-1:0] y_data
);

    localparam int FRAC_BITS = 12;
    // smallest Q8.24 sum whose Q4.12 image no longer fits
    localparam int SAT_LIMIT = 1 << (FRAC_BITS + DATA_W - 1);
    // quiet cycles after the last result, so stray strobes land in this test
    localparam int SETTLE_CYCLES = 4;

    logic [N_INPUTS*DATA_W-1:0] w_model;
    logic [N_INPUTS*DATA_W-1:0] x_model;
    logic signed [DATA_W-1:0]   b_model;
    int                         n_samples = 0;

    logic [DATA_W-1:0] expected_q[$];
    logic [DATA_W-1:0] exp_val;

    string cur_test = "none";
    int    test_results = 0;
    int    test_errors = 0;
    int    tests_run = 0;
    int    check_count = 0;
    int    error_count = 0;

    // bias on the Q8.24 point, eight products, 32-bit wrap, then ReLU and clip
    function automatic logic signed [DATA_W-1:0] ref_neuron(
        input logic [N_INPUTS*DATA_W-1:0] w_flat,
        input logic [N_INPUTS*DATA_W-1:0] x_flat,
        input logic signed [DATA_W-1:0]   b
    );
        int                       sum;
        logic signed [DATA_W-1:0] wi;
        logic signed [DATA_W-1:0] xi;
        sum = int'(b) * (1 << FRAC_BITS);
        for (int i = 0; i < N_INPUTS; i++) begin
            wi  = w_flat[i*DATA_W +: DATA_W];
            xi  = x_flat[i*DATA_W +: DATA_W];
            sum = sum + int'(wi) * int'(xi);
        end
        if (sum < 0) begin
            return '0;
        end else if (sum >= SAT_LIMIT) begin
            return OUT_MAX;
        end
        return DATA_W'(sum >>> FRAC_BITS);
    endfunction

    task automatic start_test(input string name);
        cur_test     = name;
        test_results = 0;
        test_errors  = 0;
    endtask

    task automatic note_write(input logic [3:0] addr, input logic signed [DATA_W-1:0] data);
        if (addr < 4'(N_INPUTS)) begin
            w_model[int'(addr)*DATA_W +: DATA_W] = data;
        end else if (addr == 4'(N_INPUTS)) begin
            b_model = data;
        end
    endtask

    // the eighth sample closes the vector and queues its result
    task automatic add_sample(input logic signed [DATA_W-1:0] x);
        x_model[n_samples*DATA_W +: DATA_W] = x;
        n_samples++;
        if (n_samples == N_INPUTS) begin
            expected_q.push_back(ref_neuron(w_model, x_model, b_model));
            n_samples = 0;
        end
    endtask

    task automatic count_error();
        test_errors++;
        error_count++;
    endtask

    task automatic watch_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            if (y_data !== '0) begin
                $display("error %s: expected 0x%h, actual 0x%h", cur_test, 16'h0000, y_data);
                count_error();
            end
        end
    endtask

    task automatic finish_test();
        int waited;
        waited = 0;
        while (expected_q.size() > 0 && waited < DRAIN_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        repeat (SETTLE_CYCLES) @(negedge clk);
        if (expected_q.size() > 0) begin
            $display("%s: %0d result(s) never came out of the DUT", cur_test, expected_q.size());
            count_error();
            expected_q.delete();
        end
        tests_run++;
        $display("test %-16s results %0d  errors %0d", cur_test, test_results, test_errors);
    endtask

    task automatic report_totals();
        $display("tests %0d, checks %0d, errors %0d", tests_run, check_count, error_count);
    endtask

    // one queued result is compared at every output strobe
    always @(negedge clk) begin
        if (!reset && y_valid) begin
            test_results++;
            if (expected_q.size() == 0) begin
                $display("%s: DUT gave a result 0x%h that no vector asked for", cur_test, y_data);
                count_error();
            end else begin
                exp_val = expected_q.pop_front();
                check_count++;
                if (y_data !== exp_val) begin
                    $display("error %s: expected 0x%h, actual 0x%h", cur_test, exp_val, y_data);
                    count_error();
                end
            end
        end
    end

endmodule

// File: test/tb_dense_neuron.sv
`timescale 1ns/1ps

module tb_dense_neuron
    import nn_pkg::*;
;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 3;
    localparam int IDLE_CYCLES  = 10;
    localparam int LOAD_CYCLES  = N_INPUTS + 2;
    localparam int DRAIN_CYCLES = 20;
    localparam int GAP_MAX      = 3;
    localparam int N_RANDOM     = 20;

    // worst case length of the whole run, gaps counted at their maximum
    localparam int TEST_CYCLES = RESET_CYCLES + IDLE_CYCLES
                               + 5 * (LOAD_CYCLES + DRAIN_CYCLES)
                               + (3 + 2 * (GAP_MAX + 1) + N_RANDOM) * N_INPUTS;
    localparam int TIMEOUT_CYCLES = TEST_CYCLES + 100;

    logic                     clk;
    logic                     reset;
    logic                     w_write;
    logic [3:0]               w_addr;
    logic signed [DATA_W-1:0] w_data;
    logic                     x_valid;
    logic signed [DATA_W-1:0] x_data;
    logic                     y_valid;
    logic signed [DATA_W-1:0] y_data;

    int                       seed;
    int                       gap;
    logic signed [DATA_W-1:0] val;

    dense_neuron u_dense_neuron (
        .clk     (clk),
        .reset   (reset),
        .w_write (w_write),
        .w_addr  (w_addr),
        .w_data  (w_data),
        .x_valid (x_valid),
        .x_data  (x_data),
        .y_valid (y_valid),
        .y_data  (y_data)
    );

    neuron_checker #(.DRAIN_LIMIT(DRAIN_CYCLES)) u_checker (
        .clk     (clk),
        .reset   (reset),
        .y_valid (y_valid),
        .y_data  (y_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("timeout: run did not complete within %0d cycles", TIMEOUT_CYCLES);
        $display("Finished with errors");
        $finish;
    end

    task automatic drive_idle();
        @(posedge clk);
        #2;
        w_write = 1'b0;
        x_valid = 1'b0;
    endtask

    task automatic write_reg(input logic [3:0] addr, input logic signed [DATA_W-1:0] data);
        @(posedge clk);
        #2;
        x_valid = 1'b0;
        w_write = 1'b1;
        w_addr  = addr;
        w_data  = data;
        u_checker.note_write(addr, data);
    endtask

    // optional idle cycles first, then one accepted sample
    task automatic send_sample(input logic signed [DATA_W-1:0] x, input int idle);
        repeat (idle) drive_idle();
        @(posedge clk);
        #2;
        w_write = 1'b0;
        x_valid = 1'b1;
        x_data  = x;
        u_checker.add_sample(x);
    endtask

    initial begin
        w_write = 1'b0;
        w_addr  = '0;
        w_data  = '0;
        x_valid = 1'b0;
        x_data  = '0;
        reset   = 1'b1;
        seed    = 47;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        reset = 1'b0;

        u_checker.start_test("reset_state");
        u_checker.watch_idle(IDLE_CYCLES);
        u_checker.finish_test();

        // small positive terms, sum stays inside Q4.12
        u_checker.start_test("single_positive");
        for (int i = 0; i < N_INPUTS; i++) begin
            write_reg(4'(i), DATA_W'(16'h0200 * (i + 1)));
        end
        write_reg(4'(N_INPUTS), 16'sh0300);
        for (int i = 0; i < N_INPUTS; i++) begin
            send_sample(DATA_W'(16'h0100 * (i + 1)), 0);
        end
        drive_idle();
        u_checker.finish_test();

        // +1.0 and -3.0 alternate, so four ones minus twelve
        u_checker.start_test("negative_sum");
        for (int i = 0; i < N_INPUTS; i++) begin
            write_reg(4'(i), (i % 2 == 0) ? 16'sh1000 : -16'sh3000);
        end
        write_reg(4'(N_INPUTS), 16'sh0800);
        for (int i = 0; i < N_INPUTS; i++) begin
            send_sample(16'sh1000, 0);
        end
        drive_idle();
        u_checker.finish_test();

        // 2.0 * 2.0 eight times plus 1.0 is 33, far above 8 but below 128
        u_checker.start_test("saturation");
        for (int i = 0; i < N_INPUTS; i++) begin
            write_reg(4'(i), 16'sh2000);
        end
        write_reg(4'(N_INPUTS), 16'sh1000);
        for (int i = 0; i < N_INPUTS; i++) begin
            send_sample(16'sh2000, 0);
        end
        drive_idle();
        u_checker.finish_test();

        u_checker.start_test("bias_and_gaps");
        for (int i = 0; i < N_INPUTS; i++) begin
            val = DATA_W'($random(seed));
            write_reg(4'(i), val >>> 3);
        end
        write_reg(4'(N_INPUTS), 16'sh1a40);
        for (int i = 0; i < N_INPUTS; i++) begin
            gap = {$random(seed)} % (GAP_MAX + 1);
            send_sample('0, gap);
        end
        for (int i = 0; i < N_INPUTS; i++) begin
            gap = {$random(seed)} % (GAP_MAX + 1);
            send_sample(DATA_W'($random(seed)), gap);
        end
        drive_idle();
        u_checker.finish_test();

        // weights scaled down so results spread over zero, in range and saturated
        u_checker.start_test("random_stream");
        for (int i = 0; i < N_INPUTS; i++) begin
            val = DATA_W'($random(seed));
            write_reg(4'(i), val >>> 3);
        end
        write_reg(4'(N_INPUTS), DATA_W'($random(seed)));
        for (int v = 0; v < N_RANDOM; v++) begin
            for (int i = 0; i < N_INPUTS; i++) begin
                send_sample(DATA_W'($random(seed)), 0);
            end
        end
        drive_idle();
        u_checker.finish_test();

        u_checker.report_totals();
        if (u_checker.error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: files.f
logic/nn_pkg.sv
logic/weight_store.sv
logic/neuron_mac.sv
logic/relu_sat.sv
logic/dense_neuron.sv
test/neuron_checker.sv
test/tb_dense_neuron.sv

// File: Bender.yml
package:
  name: dense_neuron

sources:
  - files:
      - logic/nn_pkg.sv
      - logic/weight_store.sv
      - logic/neuron_mac.sv
      - logic/relu_sat.sv
      - logic/dense_neuron.sv
  - target: test
    files:
      - test/neuron_checker.sv
      - test/tb_dense_neuron.sv
